/* writeback_top.f */
src/wb_pkg.sv
src/wb_if.sv
src/retire_latch.sv
src/writeback_stage.sv
src/store_queue.sv
src/arch_reg_file.sv
src/writeback_top.sv
testbench/wb_checker.sv
testbench/tb_writeback.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_writeback
FILELIST  = writeback_top.f
SIM       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	$(SIM) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* testbench/tb_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_writeback import wb_pkg::*; ();

    localparam int N_OPS = 16;
    localparam int SQ_DEPTH = 4;

    logic clk = 0;
    logic rst = 1;
    logic in_valid = 0, in_far_xfer = 0, in_br_valid = 0, in_br_taken = 0;
    logic in_br_correct = 0, in_ie = 0, interrupt = 0, mem_ready = 0;
    logic [NUM_SLOTS-1:0][DATA_W-1:0] in_data = '0;
    logic [NUM_SLOTS-1:0][ADDR_W-1:0] in_dest = '0;
    logic [NUM_SLOTS-1:0][KIND_W-1:0] in_kind = '0;
    logic [NUM_SLOTS-1:0] in_wb = '0;
    logic [SIZE_W-1:0] in_size = '0;
    logic [OVR_W-1:0] in_size_ovr = '0;
    logic [ADDR_W-1:0] in_eip = '0, in_br_fip = '0;
    logic [IE_TYPE_W-1:0] in_ie_type = '0;
    logic [REG_IDX_W-1:0] rd_gpr_addr = '0, rd_seg_addr = '0;
    logic stall, retire_valid, resteer, final_ie_val, mem_valid;
    logic [ADDR_W-1:0] new_eip, new_fip_e, new_fip_o, mem_addr;
    logic [IE_TYPE_W:0] final_ie_type;
    logic [DATA_W-1:0] mem_data;
    logic [SIZE_W-1:0] mem_size;
    logic [GPR_W-1:0] rd_gpr_data;
    logic [SEG_W-1:0] rd_seg_data;

    typedef struct packed {
        logic [7:0]  kinds;    // slot 3 .. slot 0
        logic [3:0]  wb;
        logic [11:0] dests;    // octal digit per slot
        logic [1:0]  size;
        logic [3:0]  ovr;
        logic        far;
        logic [2:0]  br;       // valid, taken, correct
        logic [31:0] fip;
        logic        ie;
        logic [2:0]  ie_type;
        logic        intr;
    } op_t;

    op_t ops [N_OPS] = '{
        '{8'b00_00_01_01, 4'b0011, 12'o0021, 2'd2, 4'b0000, 0, 3'b000, 32'h2000, 0, 0, 0},
        '{8'b01_01_00_01, 4'b1101, 12'o5505, 2'd0, 4'b0000, 0, 3'b111, 32'h3010, 0, 0, 0},
        '{8'b01_01_01_01, 4'b0000, 12'o7777, 2'd0, 4'b0000, 0, 3'b000, 32'h3020, 1, 5, 0},
        '{8'b00_00_10_10, 4'b0011, 12'o0032, 2'd0, 4'b0000, 0, 3'b100, 32'h4008, 0, 0, 0},
        '{8'b00_00_11_01, 4'b0011, 12'o0000, 2'd1, 4'b0000, 0, 3'b000, 32'h5000, 0, 0, 0},
        '{8'b00_11_00_00, 4'b0100, 12'o0000, 2'd0, 4'b0110, 0, 3'b101, 32'h5030, 0, 2, 1},
        '{8'b00_00_11_10, 4'b0011, 12'o0004, 2'd0, 4'b0001, 1, 3'b111, 32'h6000, 0, 0, 0},
        '{8'b11_00_00_00, 4'b1000, 12'o0000, 2'd0, 4'b0000, 0, 3'b000, 32'h6010, 0, 0, 0},
        '{8'b11_00_00_00, 4'b1000, 12'o1000, 2'd2, 4'b1000, 0, 3'b110, 32'h7fff, 0, 0, 0},
        '{8'b11_00_00_00, 4'b1000, 12'o2000, 2'd1, 4'b0000, 0, 3'b000, 32'h8000, 0, 0, 0},
        '{8'b11_00_01_00, 4'b1010, 12'o3030, 2'd0, 4'b0100, 0, 3'b100, 32'h8010, 0, 0, 0},
        '{8'b11_00_00_00, 4'b1000, 12'o4000, 2'd3, 4'b0000, 0, 3'b000, 32'h9000, 0, 0, 0},
        '{8'b11_00_00_00, 4'b1000, 12'o5000, 2'd0, 4'b0010, 0, 3'b000, 32'h9018, 0, 0, 0},
        '{8'b00_00_01_11, 4'b0010, 12'o0060, 2'd0, 4'b0000, 0, 3'b000, 32'ha000, 0, 0, 0},
        '{8'b00_00_00_00, 4'b0000, 12'o0000, 2'd0, 4'b0000, 0, 3'b101, 32'hb010, 1, 7, 1},
        '{8'b00_00_10_01, 4'b0011, 12'o0077, 2'd0, 4'b0000, 1, 3'b110, 32'hc000, 0, 0, 0}
    };

    logic [16:0] lfsr = 17'd78319;
    bit slow_drain = 1;    // mostly stalled memory while the table runs

    writeback_top #(.SQ_DEPTH(SQ_DEPTH)) dut (.*);
    wb_checker #(.SQ_DEPTH(SQ_DEPTH)) chk (.*);

    always #4 clk = ~clk;

    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    always @(posedge clk) begin
        logic b;
        #1;
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
        if (slow_drain) begin
            lfsr = lfsr_step(lfsr);
            b = b & lfsr[0];
            lfsr = lfsr_step(lfsr);
            b = b & lfsr[0];
        end
        mem_ready = b;
    end

    task automatic drive_op(input int k);
        op_t o;
        o = ops[k];
        in_valid = 1;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            in_data[s] = {8'ha0 + 8'(k), 8'(s), 16'h5000 + 16'(k * 16 + s),
                          32'hc000_0000 + 32'(k * 256 + s * 17)};
            in_dest[s] = 32'h0001_0000 | 32'(k << 4) | 32'(o.dests[s*3 +: 3]);
        end
        in_kind = o.kinds;
        in_wb = o.wb;
        in_size = o.size;
        in_size_ovr = o.ovr;
        in_far_xfer = o.far;
        in_eip = 32'h1000 + 32'(k * 4);
        {in_br_valid, in_br_taken, in_br_correct} = o.br;
        in_br_fip = o.fip;
        in_ie = o.ie;
        in_ie_type = o.ie_type;
        interrupt = o.intr;
    endtask

    initial begin
        repeat (5) @(posedge clk);
        #1 rst = 0;
        for (int k = 0; k < N_OPS; k++) begin
            drive_op(k);
            do @(negedge clk); while (stall);   // held until accepted
            @(posedge clk);
            #1;
        end
        in_valid = 0;
        interrupt = 0;
        slow_drain = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            @(posedge clk);
            #1;
            rd_gpr_addr = REG_IDX_W'(r);
            rd_seg_addr = REG_IDX_W'(NUM_REGS - 1 - r);
        end
        while (chk.pending != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        chk.report();
        if (chk.errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // budget of 40 cycles per table entry
    initial begin
        #(N_OPS * 40 * 8);
        $display("timeout, the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/wb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_checker import wb_pkg::*; #(
    parameter int SQ_DEPTH = 4
) (
    input wire logic                             clk,
    input wire logic                             rst,
    input wire logic                             in_valid,
    input wire logic [NUM_SLOTS-1:0][DATA_W-1:0] in_data,
    input wire logic [NUM_SLOTS-1:0][ADDR_W-1:0] in_dest,
    input wire logic [NUM_SLOTS-1:0][KIND_W-1:0] in_kind,
    input wire logic [NUM_SLOTS-1:0]             in_wb,
    input wire logic [SIZE_W-1:0]                in_size,
    input wire logic [OVR_W-1:0]                 in_size_ovr,
    input wire logic                             in_far_xfer,
    input wire logic [ADDR_W-1:0]                in_eip,
    input wire logic                             in_br_valid,
    input wire logic                             in_br_taken,
    input wire logic                             in_br_correct,
    input wire logic [ADDR_W-1:0]                in_br_fip,
    input wire logic                             in_ie,
    input wire logic [IE_TYPE_W-1:0]             in_ie_type,
    input wire logic                             interrupt,
    input wire logic                             stall,
    input wire logic                             retire_valid,
    input wire logic [ADDR_W-1:0]                new_eip,
    input wire logic [ADDR_W-1:0]                new_fip_e,
    input wire logic [ADDR_W-1:0]                new_fip_o,
    input wire logic                             resteer,
    input wire logic                             final_ie_val,
    input wire logic [IE_TYPE_W:0]               final_ie_type,
    input wire logic                             mem_valid,
    input wire logic [ADDR_W-1:0]                mem_addr,
    input wire logic [DATA_W-1:0]                mem_data,
    input wire logic [SIZE_W-1:0]                mem_size,
    input wire logic                             mem_ready,
    input wire logic [REG_IDX_W-1:0]             rd_gpr_addr,
    input wire logic [GPR_W-1:0]                 rd_gpr_data,
    input wire logic [REG_IDX_W-1:0]             rd_seg_addr,
    input wire logic [SEG_W-1:0]                 rd_seg_data
);

    int errors = 0;
    int checks = 0;
    int pending = 0;     // stores still expected on the port
    int n_ret = 0;
    int n_st = 0;
    bit stall_seen = 0;
    int m_cred = 0;      // free queue entries
    bit deq_prev = 0;    // drain last cycle, credit comes back now
    bit exp_stall = 0;
    bit exp_enq;

    // model of the latched op
    logic                             c_valid = 0;
    logic [NUM_SLOTS-1:0][DATA_W-1:0] c_data;
    logic [NUM_SLOTS-1:0][ADDR_W-1:0] c_dest;
    logic [NUM_SLOTS-1:0][KIND_W-1:0] c_kind;
    logic [NUM_SLOTS-1:0]             c_wb;
    logic [SIZE_W-1:0]                c_size;
    logic [OVR_W-1:0]                 c_ovr;
    logic                             c_far;
    logic [ADDR_W-1:0]                c_eip;
    logic [2:0]                       c_br;      // valid, taken, correct
    logic [ADDR_W-1:0]                c_fip;
    logic                             c_ie;
    logic [IE_TYPE_W-1:0]             c_ie_type;

    logic [GPR_W-1:0]  m_gpr [NUM_REGS] = '{default: '0};
    logic [SEG_W-1:0]  m_seg [NUM_REGS] = '{default: '0};
    logic [ADDR_W-1:0] q_addr [$];
    logic [DATA_W-1:0] q_data [$];
    logic [SIZE_W-1:0] q_size [$];

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic bit holds_store();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (c_wb[s] && c_kind[s] == KIND_MEM) begin
                return 1;
            end
        end
        return 0;
    endfunction

    task automatic check_retire();
        logic [ADDR_W-1:0] tgt;
        logic [ADDR_W-1:0] line;
        logic [SIZE_W-1:0] sz;
        int e0;
        bit stored;
        e0 = errors;
        stored = 0;
        tgt = c_far ? c_data[0][31:0] : c_fip;
        line = {c_fip[31:4], 4'h0};
        compare("new_eip", new_eip, c_br[1] ? tgt : c_eip);
        compare("new_fip_e", new_fip_e, c_fip[4] ? line + 16 : line);
        compare("new_fip_o", new_fip_o, c_fip[4] ? line : line + 16);
        compare("resteer", resteer, c_br[2] && !c_br[0]);
        compare("final_ie_val", final_ie_val, c_ie || interrupt);
        compare("final_ie_type", final_ie_type, {interrupt, c_ie_type});
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (c_wb[s] && c_kind[s] == KIND_REG) begin
                m_gpr[c_dest[s][2:0]] = c_data[s][31:0];
            end else if (c_wb[s] && c_kind[s] == KIND_SEG) begin
                m_seg[c_dest[s][2:0]] = (s == 0 && c_far) ? c_data[0][47:32] : c_data[s][15:0];
            end else if (c_wb[s] && c_kind[s] == KIND_MEM && !stored) begin
                stored = 1;
                sz = c_size;
                for (int n = OVR_W - 1; n >= 0; n--) begin
                    if (c_ovr[n]) sz = SIZE_W'(n);   // lowest set bit wins
                end
                q_addr.push_back(c_dest[s]);
                q_data.push_back(c_data[s]);
                q_size.push_back(c_far ? 2'b11 : sz);
                pending++;
            end
        end
        $display("retire %0d eip %h %s", n_ret, c_eip, (errors == e0) ? "ok" : "failed");
        n_ret++;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            c_valid = 0;
            m_cred = SQ_DEPTH;
            deq_prev = 0;
        end else begin
            exp_stall = c_valid && holds_store() && (m_cred == 0);
            exp_enq = c_valid && holds_store() && !exp_stall;
            compare("rd_gpr_data", rd_gpr_data, m_gpr[rd_gpr_addr]);
            compare("rd_seg_data", rd_seg_data, m_seg[rd_seg_addr]);
            compare("stall", stall, exp_stall);
            compare("retire_valid", retire_valid, c_valid && !exp_stall);
            if (stall) begin
                stall_seen = 1;
            end
            if (c_valid && !exp_stall) check_retire();
            if (mem_valid && mem_ready) begin
                if (pending == 0) begin
                    $display("store to %h appeared that was never issued", mem_addr);
                    errors++;
                end else begin
                    compare("mem_addr", mem_addr, q_addr.pop_front());
                    compare("mem_data", mem_data, q_data.pop_front());
                    compare("mem_size", mem_size, q_size.pop_front());
                    pending--;
                    $display("store %0d drained", n_st);
                    n_st++;
                end
            end
            // credits as the stage holds them after the next edge
            m_cred = m_cred + (deq_prev ? 1 : 0) - (exp_enq ? 1 : 0);
            deq_prev = mem_valid && mem_ready;
            if (!exp_stall) begin
                c_valid = in_valid;
                c_data = in_data;
                c_dest = in_dest;
                c_kind = in_kind;
                c_wb = in_wb;
                c_size = in_size;
                c_ovr = in_size_ovr;
                c_far = in_far_xfer;
                c_eip = in_eip;
                c_br = {in_br_valid, in_br_taken, in_br_correct};
                c_fip = in_br_fip;
                c_ie = in_ie;
                c_ie_type = in_ie_type;
            end
        end
    end

    task automatic report();
        if (!stall_seen) begin
            $display("stall never rose under memory back-pressure");
            errors++;
        end
        $display("retired %0d, stores %0d, checks %0d, errors %0d", n_ret, n_st, checks, errors);
    endtask

endmodule

`default_nettype wire

/* src/writeback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_top import wb_pkg::*; #(
    parameter int SQ_DEPTH = 4
) (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             in_valid,
    input  wire logic [NUM_SLOTS-1:0][DATA_W-1:0] in_data,
    input  wire logic [NUM_SLOTS-1:0][ADDR_W-1:0] in_dest,
    input  wire logic [NUM_SLOTS-1:0][KIND_W-1:0] in_kind,
    input  wire logic [NUM_SLOTS-1:0]             in_wb,
    input  wire logic [SIZE_W-1:0]                in_size,
    input  wire logic [OVR_W-1:0]                 in_size_ovr,
    input  wire logic                             in_far_xfer,
    input  wire logic [ADDR_W-1:0]                in_eip,
    input  wire logic                             in_br_valid,
    input  wire logic                             in_br_taken,
    input  wire logic                             in_br_correct,
    input  wire logic [ADDR_W-1:0]                in_br_fip,
    input  wire logic                             in_ie,
    input  wire logic [IE_TYPE_W-1:0]             in_ie_type,
    input  wire logic                             interrupt,
    output logic                                  stall,
    output logic                                  retire_valid,
    output logic      [ADDR_W-1:0]                new_eip,
    output logic      [ADDR_W-1:0]                new_fip_e,
    output logic      [ADDR_W-1:0]                new_fip_o,
    output logic                                  resteer,
    output logic                                  final_ie_val,
    output logic      [IE_TYPE_W:0]               final_ie_type,
    output logic                                  mem_valid,
    output logic      [ADDR_W-1:0]                mem_addr,
    output logic      [DATA_W-1:0]                mem_data,
    output logic      [SIZE_W-1:0]                mem_size,
    input  wire logic                             mem_ready,
    input  wire logic [REG_IDX_W-1:0]             rd_gpr_addr,
    output logic      [GPR_W-1:0]                 rd_gpr_data,
    input  wire logic [REG_IDX_W-1:0]             rd_seg_addr,
    output logic      [SEG_W-1:0]                 rd_seg_data
);

    retire_if rif ();
    sq_if     sq ();

    assign stall = rif.stall;

    retire_latch u_latch (
        .clk, .rst, .in_valid, .in_data, .in_dest, .in_kind, .in_wb,
        .in_size, .in_size_ovr, .in_far_xfer, .in_eip, .in_br_valid,
        .in_br_taken, .in_br_correct, .in_br_fip, .in_ie, .in_ie_type,
        .rif (rif)
    );

    writeback_stage #(.SQ_DEPTH(SQ_DEPTH)) u_stage (
        .clk, .rst, .interrupt,
        .rif (rif),
        .sq  (sq),
        .new_eip, .new_fip_e, .new_fip_o, .resteer,
        .final_ie_val, .final_ie_type, .retire_valid
    );

    arch_reg_file u_regs (
        .clk, .rst,
        .rif     (rif),
        .retire  (rif.retire),
        .seg_sel (rif.far_xfer),
        .rd_gpr_addr, .rd_gpr_data, .rd_seg_addr, .rd_seg_data
    );

    store_queue #(.SQ_DEPTH(SQ_DEPTH)) u_sq (
        .clk, .rst,
        .sq (sq),
        .mem_valid, .mem_addr, .mem_data, .mem_size, .mem_ready
    );

endmodule

`default_nettype wire

/* src/arch_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_reg_file import wb_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    retire_if.dst                     rif,
    input  wire logic                 retire,
    input  wire logic                 seg_sel,     // slot 0 carries a far pointer
    input  wire logic [REG_IDX_W-1:0] rd_gpr_addr,
    output logic      [GPR_W-1:0]     rd_gpr_data,
    input  wire logic [REG_IDX_W-1:0] rd_seg_addr,
    output logic      [SEG_W-1:0]     rd_seg_data
);

    logic [GPR_W-1:0] gpr [NUM_REGS];
    logic [SEG_W-1:0] seg [NUM_REGS];

    // slots written in order so the higher slot wins
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                gpr[r] <= '0;
                seg[r] <= '0;
            end
        end else if (retire) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (rif.wb[i] && rif.kind[i] == KIND_REG) begin
                    gpr[rif.dest[i][REG_IDX_W-1:0]] <= rif.data[i].raw[GPR_W-1:0];
                end
                if (rif.wb[i] && rif.kind[i] == KIND_SEG) begin
                    if (i == 0 && seg_sel) begin
                        seg[rif.dest[i][REG_IDX_W-1:0]] <= rif.data[i].far_ptr.sel;
                    end else begin
                        seg[rif.dest[i][REG_IDX_W-1:0]] <= rif.data[i].raw[SEG_W-1:0];
                    end
                end
            end
        end
    end

    assign rd_gpr_data = gpr[rd_gpr_addr];
    assign rd_seg_data = seg[rd_seg_addr];

endmodule

`default_nettype wire

/* src/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue import wb_pkg::*; #(
    parameter int SQ_DEPTH = 4
) (
    input  wire logic          clk,
    input  wire logic          rst,
    sq_if.queue                sq,
    output logic               mem_valid,
    output logic [ADDR_W-1:0]  mem_addr,
    output logic [DATA_W-1:0]  mem_data,
    output logic [SIZE_W-1:0]  mem_size,
    input  wire logic          mem_ready
);

    localparam int PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    logic [ADDR_W-1:0] addr_q [SQ_DEPTH];
    logic [DATA_W-1:0] data_q [SQ_DEPTH];
    logic [SIZE_W-1:0] size_q [SQ_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              deq;
    logic              full;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(SQ_DEPTH - 1)) begin
            return '0;
        end
        return p + PTR_W'(1);
    endfunction

    assign full      = (count == CNT_W'(SQ_DEPTH));
    assign mem_valid = (count != '0);
    assign deq       = mem_valid && mem_ready;

    assign mem_addr = addr_q[rd_ptr];
    assign mem_data = data_q[rd_ptr];
    assign mem_size = size_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (sq.enq) begin
            addr_q[wr_ptr] <= sq.addr;
            data_q[wr_ptr] <= sq.data;
            size_q[wr_ptr] <= sq.size;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            sq.credit <= 1'b0;
        end else begin
            if (sq.enq) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({sq.enq, deq})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
            sq.credit <= deq;   // freed slot goes back next cycle
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        sq.enq |-> !full || deq);

    // pointers must agree that something is queued
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        deq |-> (rd_ptr != wr_ptr) || full);

endmodule

`default_nettype wire

/* src/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import wb_pkg::*; #(
    parameter int SQ_DEPTH = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 interrupt,
    retire_if.dst                     rif,
    sq_if.stage                       sq,
    output logic [ADDR_W-1:0]         new_eip,
    output logic [ADDR_W-1:0]         new_fip_e,
    output logic [ADDR_W-1:0]         new_fip_o,
    output logic                      resteer,
    output logic                      final_ie_val,
    output logic [IE_TYPE_W:0]        final_ie_type,
    output logic                      retire_valid
);

    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    logic [NUM_SLOTS-1:0] mem_hit;
    logic                 any_mem;
    logic [SLOT_W-1:0]    st_idx;
    logic [SIZE_W-1:0]    st_size;
    logic [CNT_W-1:0]     credits;
    logic                 has_credit;
    logic                 enq;
    logic [ADDR_W-1:0]    target;
    logic [ADDR_W-1:0]    line;
    logic [ADDR_W-1:0]    line_next;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            mem_hit[i] = rif.valid && rif.wb[i] && (rif.kind[i] == KIND_MEM);
        end
    end

    assign any_mem = |mem_hit;

    // lowest memory slot is the store
    always_comb begin
        st_idx = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_hit[i]) begin
                st_idx = SLOT_W'(i);
            end
        end
    end

    // far, then lowest override bit, then op size
    always_comb begin
        st_size = rif.size;
        if (rif.far_xfer) begin
            st_size = SIZE_FAR;
        end else if (|rif.size_ovr) begin
            for (int n = OVR_W - 1; n >= 0; n--) begin
                if (rif.size_ovr[n]) begin
                    st_size = SIZE_W'(n);
                end
            end
        end
    end

    assign has_credit   = (credits != '0);
    assign rif.stall    = rif.valid && any_mem && !has_credit;
    assign rif.retire   = rif.valid && !rif.stall;
    assign retire_valid = rif.retire;
    assign enq          = rif.retire && any_mem;

    assign sq.enq  = enq;
    assign sq.addr = rif.dest[st_idx];
    assign sq.data = rif.data[st_idx].raw;
    assign sq.size = st_size;

    // free queue entries as seen from here
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CNT_W'(SQ_DEPTH);
        end else begin
            case ({enq, sq.credit})
                2'b10:   credits <= credits - CNT_W'(1);
                2'b01:   credits <= credits + CNT_W'(1);
                default: credits <= credits;
            endcase
        end
    end

    // far jump target comes from the slot 0 offset
    assign target  = rif.far_xfer ? rif.data[0].far_ptr.offset : rif.br_fip;
    assign new_eip = rif.br_taken ? target : rif.eip;

    assign line      = {rif.br_fip[ADDR_W-1:4], 4'b0000};
    assign line_next = line + ADDR_W'(16);
    assign new_fip_e = rif.br_fip[4] ? line_next : line;
    assign new_fip_o = rif.br_fip[4] ? line : line_next;

    assign resteer = rif.retire && rif.br_valid && !rif.br_correct;

    assign final_ie_val  = (rif.valid && rif.ie) || interrupt;
    assign final_ie_type = {interrupt, rif.ie_type};   // interrupt on top

    a_one_store: assert property (@(posedge clk) disable iff (rst)
        $onehot0(mem_hit));

    // queue never hands back more than it holds
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CNT_W'(SQ_DEPTH));

endmodule

`default_nettype wire

/* src/retire_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_latch import wb_pkg::*; (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic                                 in_valid,
    input  wire logic [NUM_SLOTS-1:0][DATA_W-1:0]     in_data,
    input  wire logic [NUM_SLOTS-1:0][ADDR_W-1:0]     in_dest,
    input  wire logic [NUM_SLOTS-1:0][KIND_W-1:0]     in_kind,
    input  wire logic [NUM_SLOTS-1:0]                 in_wb,
    input  wire logic [SIZE_W-1:0]                    in_size,
    input  wire logic [OVR_W-1:0]                     in_size_ovr,
    input  wire logic                                 in_far_xfer,
    input  wire logic [ADDR_W-1:0]                    in_eip,
    input  wire logic                                 in_br_valid,
    input  wire logic                                 in_br_taken,
    input  wire logic                                 in_br_correct,
    input  wire logic [ADDR_W-1:0]                    in_br_fip,
    input  wire logic                                 in_ie,
    input  wire logic [IE_TYPE_W-1:0]                 in_ie_type,
    retire_if.src                                     rif
);

    // valid drops when the retired op has no successor
    always_ff @(posedge clk) begin
        if (rst) begin
            rif.valid <= 1'b0;
        end else if (!rif.stall) begin
            rif.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rif.stall) begin   // hold the op while stalled
            rif.data       <= in_data;
            rif.dest       <= in_dest;
            rif.kind       <= in_kind;
            rif.wb         <= in_wb;
            rif.size       <= in_size;
            rif.size_ovr   <= in_size_ovr;
            rif.far_xfer   <= in_far_xfer;
            rif.eip        <= in_eip;
            rif.br_valid   <= in_br_valid;
            rif.br_taken   <= in_br_taken;
            rif.br_correct <= in_br_correct;
            rif.br_fip     <= in_br_fip;
            rif.ie         <= in_ie;
            rif.ie_type    <= in_ie_type;
        end
    end

endmodule

`default_nettype wire

/* src/wb_if.sv */
`timescale 1ns/1ps
`default_nettype none

// retiring micro-op, latch to writeback and register file
interface retire_if import wb_pkg::*; ();

    logic                                 valid;
    wb_word_u [NUM_SLOTS-1:0]             data;
    logic     [NUM_SLOTS-1:0][ADDR_W-1:0] dest;
    logic     [NUM_SLOTS-1:0][KIND_W-1:0] kind;
    logic     [NUM_SLOTS-1:0]             wb;
    logic     [SIZE_W-1:0]                size;
    logic     [OVR_W-1:0]                 size_ovr;
    logic                                 far_xfer;
    logic     [ADDR_W-1:0]                eip;
    logic                                 br_valid;
    logic                                 br_taken;
    logic                                 br_correct;
    logic     [ADDR_W-1:0]                br_fip;
    logic                                 ie;
    logic     [IE_TYPE_W-1:0]             ie_type;
    logic                                 stall;    // back from writeback
    logic                                 retire;

    modport src (
        output valid, data, dest, kind, wb, size, size_ovr, far_xfer, eip,
        output br_valid, br_taken, br_correct, br_fip, ie, ie_type,
        input  stall, retire
    );

    modport dst (
        input  valid, data, dest, kind, wb, size, size_ovr, far_xfer, eip,
        input  br_valid, br_taken, br_correct, br_fip, ie, ie_type,
        output stall, retire
    );

endinterface

// store path, writeback to store queue
interface sq_if import wb_pkg::*; ();

    logic              enq;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [SIZE_W-1:0] size;
    logic              credit;   // one pulse per freed entry

    modport stage (output enq, addr, data, size, input credit);
    modport queue (input enq, addr, data, size, output credit);

endinterface

`default_nettype wire

/* src/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // slots per retiring micro-op
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_W    = 2;

    localparam int DATA_W    = 64;
    localparam int ADDR_W    = 32;   // reg index or store address

    localparam int SIZE_W    = 2;
    localparam int OVR_W     = 4;    // one override bit per size code
    localparam int IE_TYPE_W = 3;

    localparam int GPR_W     = 32;
    localparam int SEG_W     = 16;
    localparam int NUM_REGS  = 8;
    localparam int REG_IDX_W = 3;

    localparam logic [SIZE_W-1:0] SIZE_FAR = 2'b11;   // far pointer store

    // slot destination kinds
    localparam int KIND_W = 2;
    localparam logic [KIND_W-1:0] KIND_NONE = 2'd0;
    localparam logic [KIND_W-1:0] KIND_REG  = 2'd1;
    localparam logic [KIND_W-1:0] KIND_SEG  = 2'd2;
    localparam logic [KIND_W-1:0] KIND_MEM  = 2'd3;

    typedef struct packed {
        logic [15:0] pad;
        logic [15:0] sel;      // segment selector
        logic [31:0] offset;
    } far_ptr_t;

    // one result word, read raw or as a far pointer
    typedef union packed {
        logic [DATA_W-1:0] raw;
        far_ptr_t          far_ptr;
    } wb_word_u;

endpackage

`default_nettype wire
